// ==== Makefile ====
obj_dir/VsifhTb: filelist.f $(shell cat filelist.f)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module sifhTb

run: obj_dir/VsifhTb
	./obj_dir/VsifhTb | tee sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== filelist.f ====
source/sifhPkg.sv
source/histRam.sv
source/eventFifo.sv
source/histBuilder.sv
source/peakFinder.sv
source/sifhCtrl.sv
source/sifhTop.sv
tests/sifhTb.sv

// ==== source/eventFifo.sv ====
module eventFifo import sifhPkg::*; (
    input  logic  clk,
    input  logic  res,
    input  eventT tdcIn,
    input  logic  pop,
    output eventT head,
    output logic  creditReturn
);

    logic [timeBits-1:0]    stampMem [fifoDepth];
    logic [fifoPtrBits-1:0] wrPtr;
    logic [fifoPtrBits-1:0] rdPtr;
    logic [fifoPtrBits:0]   count;

    assign head = '{valid: (count != '0), stamp: stampMem[rdPtr]};
    assign creditReturn = pop && head.valid;    // one credit per released event

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (tdcIn.valid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (creditReturn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({tdcIn.valid, creditReturn})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tdcIn.valid) begin
            stampMem[wrPtr] <= tdcIn.stamp;
        end
    end

    // TDC must hold a credit for every event it sends
    assert property (@(posedge clk) disable iff (!res) tdcIn.valid |-> count != fifoDepth)
        else $error("eventFifo: event written while full, credit violation");

    assert property (@(posedge clk) disable iff (!res) pop |-> head.valid)
        else $error("eventFifo: pop while empty");

endmodule

// ==== source/histBuilder.sv ====
module histBuilder import sifhPkg::*; (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 buildEn,
    input  binOpT                winBase,
    input  eventT                head,
    output logic                 pop,
    output logic [binBits-1:0]   rAddr,
    input  logic [countBits-1:0] rData,
    output logic                 wEn,
    output logic [binBits-1:0]   wAddr,
    output logic [countBits-1:0] wData,
    output logic                 buildDone
);

    logic [timeBits-1:0]    lo;
    logic [timeBits-1:0]    offset;
    logic                   inWin;
    logic [passCntBits-1:0] consumed;
    logic                   passFull;
    logic                   s1Pop;      // stage 1 holds a consumed event
    logic                   s1Valid;    // ... and it gets counted
    logic [binBits-1:0]     s1Bin;
    logic                   prevValid;
    logic [binBits-1:0]     prevBin;
    logic [countBits-1:0]   prevData;
    logic [countBits-1:0]   base;

    assign lo = windowLo(winBase.binAddr);
    assign offset = head.stamp - lo;
    assign inWin = (head.stamp >= lo) && (offset < timeBits'(binNum));
    assign passFull = (consumed == passCntBits'(eventsPerPass));
    assign pop = buildEn && head.valid && !passFull;

    // bin lookup goes to the RAM in the pop cycle
    assign rAddr = winBase.fine ? offset[binBits-1:0] : binBits'(head.stamp >> coarseShift);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            consumed <= '0;
            s1Pop <= 1'b0;
            s1Valid <= 1'b0;
            prevValid <= 1'b0;
        end else begin
            consumed <= buildEn ? consumed + passCntBits'(pop) : '0;
            s1Pop <= pop;
            s1Valid <= pop && (inWin || !winBase.fine);     // out-of-window events are dropped
            prevValid <= wEn;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= rAddr;
        prevBin <= wAddr;
        prevData <= wData;
    end

    // the RAM returned stale data if the previous write hit the same bin
    assign base = (prevValid && prevBin == s1Bin) ? prevData : rData;

    assign wEn = s1Valid;
    assign wAddr = s1Bin;
    assign wData = (base == '1) ? base : base + 1'b1;  // saturate

    assign buildDone = buildEn && passFull && !s1Pop;   // last write has landed

    // the sequencer only routes builder writes to the RAM during a build phase
    assert property (@(posedge clk) disable iff (!res) wEn |-> buildEn)
        else $error("histBuilder: RAM write outside a build pass");

endmodule

// ==== source/histRam.sv ====
module histRam import sifhPkg::*; (
    input  logic                 clk,
    input  logic                 wEn,
    input  logic [binBits-1:0]   wAddr,
    input  logic [countBits-1:0] wData,
    input  logic [binBits-1:0]   rAddr,
    output logic [countBits-1:0] rData
);

    logic [countBits-1:0] mem [binNum];

    always_ff @(posedge clk) begin
        if (wEn) begin
            mem[wAddr] <= wData;
        end
        rData <= mem[rAddr];    // old data on a same-address collision
    end

endmodule

// ==== source/peakFinder.sv ====
module peakFinder import sifhPkg::*; (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 findStart,
    output logic [binBits-1:0]   rAddr,
    input  logic [countBits-1:0] rData,
    output logic [binBits-1:0]   peakBin,
    output logic [countBits-1:0] peakCount,
    output logic                 findDone
);

    logic               scanning;   // read addresses being issued
    logic [binBits-1:0] addr;
    logic               pendValid;  // rData belongs to pendBin
    logic               pendLast;
    logic [binBits-1:0] pendBin;

    assign rAddr = addr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            addr <= '0;
            pendValid <= 1'b0;
            pendLast <= 1'b0;
            findDone <= 1'b0;
            peakBin <= '0;
            peakCount <= '0;
        end else begin
            pendValid <= scanning;
            pendLast <= scanning && (addr == binBits'(binNum - 1));
            findDone <= pendValid && pendLast;
            if (findStart) begin
                scanning <= 1'b1;
                addr <= '0;
                peakBin <= '0;
                peakCount <= '0;
            end else begin
                if (scanning) begin
                    addr <= addr + 1'b1;
                    if (addr == binBits'(binNum - 1)) begin
                        scanning <= 1'b0;
                    end
                end
                // strict compare keeps the lower bin on a tie
                if (pendValid && rData > peakCount) begin
                    peakBin <= pendBin;
                    peakCount <= rData;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        pendBin <= addr;
    end

endmodule

// ==== source/sifhCtrl.sv ====
module sifhCtrl import sifhPkg::*; (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 start,
    input  logic                 buildDone,
    input  logic                 findDone,
    input  logic [binBits-1:0]   peakBin,
    input  logic [countBits-1:0] peakCount,
    output logic                 buildEn,
    output binOpT                winBase,
    output logic                 findStart,
    input  logic                 bldWEn,
    input  logic [binBits-1:0]   bldWAddr,
    input  logic [countBits-1:0] bldWData,
    input  logic [binBits-1:0]   bldRAddr,
    input  logic [binBits-1:0]   finRAddr,
    output logic                 wEn,
    output logic [binBits-1:0]   wAddr,
    output logic [countBits-1:0] wData,
    output logic [binBits-1:0]   rAddr,
    output resultT               result,
    output logic                 resValid
);

    phaseT               phase;
    phaseT               nextPhase;
    logic [binBits-1:0]  clrAddr;
    logic                clearing;
    logic                sweepEnd;
    logic [binBits-1:0]  coarsePeak;
    logic [timeBits-1:0] lo;           // fine window low bound

    assign clearing = (phase == clear1) || (phase == clear2);
    assign sweepEnd = (clrAddr == binBits'(binNum - 1));
    assign buildEn = (phase == build1) || (phase == build2);
    assign winBase = '{binAddr: coarsePeak, fine: (phase == build2)};

    always_comb begin
        nextPhase = phase;
        case (phase)
            idle:    if (start) nextPhase = clear1;
            clear1:  if (sweepEnd) nextPhase = build1;
            build1:  if (buildDone) nextPhase = find1;
            find1:   if (findDone) nextPhase = filter;
            filter:  nextPhase = clear2;
            clear2:  if (sweepEnd) nextPhase = build2;
            build2:  if (buildDone) nextPhase = find2;
            find2:   if (findDone) nextPhase = idle;
            default: nextPhase = idle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= idle;
            clrAddr <= '0;
            findStart <= 1'b0;
            resValid <= 1'b0;
        end else begin
            phase <= nextPhase;
            clrAddr <= clearing ? clrAddr + 1'b1 : '0;  // wraps to 0 after 64 writes
            findStart <= buildEn && buildDone;
            resValid <= (phase == find2) && findDone;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == find1 && findDone) begin
            coarsePeak <= peakBin;
        end
        if (phase == filter) begin
            lo <= windowLo(coarsePeak);
        end
        if (phase == find2 && findDone) begin
            result.coarsePeak <= coarsePeak;
            result.peakTime <= lo + timeBits'(peakBin);
            result.peakCount <= peakCount;
        end
    end

    // RAM port ownership follows the phase
    always_comb begin
        wEn = 1'b0;
        wAddr = clrAddr;
        wData = '0;
        rAddr = finRAddr;
        case (phase)
            clear1, clear2: wEn = 1'b1;     // zeroing sweep
            build1, build2: begin
                wEn = bldWEn;
                wAddr = bldWAddr;
                wData = bldWData;
                rAddr = bldRAddr;
            end
            default: ;
        endcase
    end

    // a peak report outside a find phase would be lost or latched wrongly
    assert property (@(posedge clk) disable iff (!res)
                     findDone |-> (phase == find1) || (phase == find2))
        else $error("sifhCtrl: peak result outside a find phase");

endmodule

// ==== source/sifhPkg.sv ====
package sifhPkg;

    localparam int timeBits = 10;       // TDC timestamp width
    localparam int binBits = 6;
    localparam int binNum = 64;
    localparam int countBits = 8;       // counts saturate at 255
    localparam int coarseShift = 4;     // 16 ticks per coarse bin
    localparam int eventsPerPass = 96;
    localparam int windowLead = 24;     // window opens this far before the coarse peak
    localparam int fifoDepth = 4;       // also the initial TDC credit count

    localparam int fifoPtrBits = $clog2(fifoDepth);
    localparam int passCntBits = $clog2(eventsPerPass + 1);
    localparam int loMax = (1 << timeBits) - binNum;    // 960 keeps the window in range

    typedef enum logic [2:0] {
        idle,
        clear1,
        build1,
        find1,
        filter,
        clear2,
        build2,
        find2
    } phaseT;

    typedef struct packed {
        logic valid;
        logic [timeBits-1:0] stamp;
    } eventT;

    typedef struct packed {
        logic [binBits-1:0] binAddr;    // coarse peak bin, window base
        logic fine;                     // 1 selects the fine pass
    } binOpT;

    typedef struct packed {
        logic [binBits-1:0] coarsePeak;
        logic [timeBits-1:0] peakTime;
        logic [countBits-1:0] peakCount;
    } resultT;

    // Lower window bound from the coarse peak bin, clamped so that all
    // 64 fine bins stay inside the timestamp range.
    function automatic logic [timeBits-1:0] windowLo(input logic [binBits-1:0] peak);
        int lo;
        lo = int'(peak) * (1 << coarseShift) - windowLead;
        if (lo < 0) begin
            lo = 0;
        end
        if (lo > loMax) begin
            lo = loMax;
        end
        return lo[timeBits-1:0];
    endfunction

endpackage

// ==== source/sifhTop.sv ====
module sifhTop import sifhPkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   start,
    input  eventT  tdcIn,
    output logic   creditReturn,
    output resultT result,
    output logic   resValid
);

    eventT                head;
    logic                 pop;
    logic                 buildEn;
    logic                 buildDone;
    binOpT                winBase;
    logic                 findStart;
    logic                 findDone;
    logic [binBits-1:0]   peakBin;
    logic [countBits-1:0] peakCount;
    logic                 bldWEn;
    logic [binBits-1:0]   bldWAddr;
    logic [countBits-1:0] bldWData;
    logic [binBits-1:0]   bldRAddr;
    logic [binBits-1:0]   finRAddr;
    logic                 wEn;
    logic [binBits-1:0]   wAddr;
    logic [countBits-1:0] wData;
    logic [binBits-1:0]   rAddr;
    logic [countBits-1:0] rData;    // shared by builder and finder

    eventFifo eventFifo_i (
        .clk          (clk),
        .res          (res),
        .tdcIn        (tdcIn),
        .pop          (pop),
        .head         (head),
        .creditReturn (creditReturn)
    );

    histBuilder histBuilder_i (
        .clk       (clk),
        .res       (res),
        .buildEn   (buildEn),
        .winBase   (winBase),
        .head      (head),
        .pop       (pop),
        .rAddr     (bldRAddr),
        .rData     (rData),
        .wEn       (bldWEn),
        .wAddr     (bldWAddr),
        .wData     (bldWData),
        .buildDone (buildDone)
    );

    peakFinder peakFinder_i (
        .clk       (clk),
        .res       (res),
        .findStart (findStart),
        .rAddr     (finRAddr),
        .rData     (rData),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .findDone  (findDone)
    );

    sifhCtrl sifhCtrl_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .buildDone (buildDone),
        .findDone  (findDone),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .buildEn   (buildEn),
        .winBase   (winBase),
        .findStart (findStart),
        .bldWEn    (bldWEn),
        .bldWAddr  (bldWAddr),
        .bldWData  (bldWData),
        .bldRAddr  (bldRAddr),
        .finRAddr  (finRAddr),
        .wEn       (wEn),
        .wAddr     (wAddr),
        .wData     (wData),
        .rAddr     (rAddr),
        .result    (result),
        .resValid  (resValid)
    );

    histRam histRam_i (
        .clk   (clk),
        .wEn   (wEn),
        .wAddr (wAddr),
        .wData (wData),
        .rAddr (rAddr),
        .rData (rData)
    );

endmodule

// ==== tests/sifhTb.sv ====
module sifhTb import sifhPkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    typedef logic [timeBits-1:0] stampListT [2*eventsPerPass];

    logic   clk = 1'b0;
    logic   res = 1'b0;
    logic   start = 1'b0;
    eventT  tdcIn = '0;
    logic   creditReturn;
    resultT result;
    logic   resValid;

    int        seed = 96381;
    int        maxWait = 5000;      // cycles allowed per run
    stampListT stamps;
    resultT    expected;
    string     testName = "none";
    int        errors = 0;
    int        passTests = 0;
    int        failTests = 0;
    int        doneCnt = 0;
    logic      hung = 1'b0;         // a run timed out, later tests are skipped

    logic tdcArm = 1'b0;            // restarts the TDC list
    logic stallOn = 1'b0;
    int   credits = fifoDepth;
    int   sendIdx = 2 * eventsPerPass;
    int   sent = 0;
    int   returned = 0;

    sifhTop sifhTop_i (
        .clk          (clk),
        .res          (res),
        .start        (start),
        .tdcIn        (tdcIn),
        .creditReturn (creditReturn),
        .result       (result),
        .resValid     (resValid)
    );

    always #50 clk = ~clk;

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // expected result straight from the bin, window, saturation and tie rules
    function automatic resultT peakRef(input stampListT list);
        int coarse [binNum];
        int fine [binNum];
        int i;
        int pk;
        int fp;
        int best;
        int lo;
        int off;
        resultT r;
        for (i = 0; i < binNum; i++) begin
            coarse[i] = 0;
            fine[i] = 0;
        end
        for (i = 0; i < eventsPerPass; i++) begin
            off = int'(list[i]) / 16;   // 16 ticks per coarse bin
            coarse[off] = (coarse[off] < 255) ? coarse[off] + 1 : 255;
        end
        pk = 0;
        best = 0;
        for (i = 0; i < binNum; i++) begin
            if (coarse[i] > best) begin
                best = coarse[i];
                pk = i;
            end
        end
        lo = pk * 16 - windowLead;
        lo = (lo < 0) ? 0 : lo;
        lo = (lo > 1024 - binNum) ? 1024 - binNum : lo;
        for (i = eventsPerPass; i < 2 * eventsPerPass; i++) begin
            off = int'(list[i]) - lo;
            if (off >= 0 && off < binNum) begin
                fine[off] = (fine[off] < 255) ? fine[off] + 1 : 255;
            end
        end
        fp = 0;
        best = 0;
        for (i = 0; i < binNum; i++) begin
            if (fine[i] > best) begin
                best = fine[i];
                fp = i;
            end
        end
        r.coarsePeak = binBits'(pk);
        r.peakTime = timeBits'(lo + fp);
        r.peakCount = countBits'(best);
        return r;
    endfunction

    task automatic fillRandom();
        int i;
        for (i = 0; i < 2 * eventsPerPass; i++) begin
            stamps[i] = timeBits'(randBelow(1 << timeBits));
        end
    endtask

    // every second slot from first on gets a stamp near center
    task automatic plantCluster(input int first, input int count, input int center,
                                input int spread);
        int k;
        for (k = 0; k < count; k++) begin
            stamps[first + 2 * k] = timeBits'(center + randBelow(spread));
        end
    endtask

    task automatic buildTies();
        int i;
        for (i = 0; i < eventsPerPass; i++) begin
            stamps[i] = (i % 2 == 0) ? 10'd323 : 10'd195;                  // coarse 20 vs 12
            stamps[eventsPerPass + i] = (i % 2 == 0) ? 10'd200 : 10'd180;  // fine 32 vs 12
        end
    endtask

    task automatic buildBursts();
        int i;
        int base;
        logic [timeBits-1:0] v;
        base = randBelow(900);
        v = '0;
        for (i = 0; i < 2 * eventsPerPass; i++) begin
            if (i % 8 == 0) begin
                v = timeBits'(base + randBelow(48));
            end
            stamps[i] = v;  // runs of 8 identical stamps
        end
    endtask

    task automatic checkResult(input string name, input resultT exp, input resultT act);
        if (act !== exp) begin
            $write("ERR %s: expected coarse %0d time %0d count %0d",
                   name, exp.coarsePeak, exp.peakTime, exp.peakCount);
            $display(", actual coarse %0d time %0d count %0d",
                     act.coarsePeak, act.peakTime, act.peakCount);
            errors++;
        end
    endtask

    task automatic checkCredits(input string name, input int expReturned,
                                input int actReturned, input int left);
        if (actReturned != expReturned || left != fifoDepth) begin
            $display("ERR %s: expected credits returned %0d held %0d, actual returned %0d held %0d",
                     name, expReturned, fifoDepth, actReturned, left);
            errors++;
        end
    endtask

    // TDC model that sends only while it holds a credit
    always @(posedge clk or negedge res) begin
        if (!res) begin
            tdcIn <= '0;
            credits = fifoDepth;
            sendIdx = 2 * eventsPerPass;
            sent = 0;
            returned = 0;
        end else begin
            if (tdcArm) begin
                sendIdx = 0;
                sent = 0;
                returned = 0;
            end
            if (creditReturn) begin
                credits++;
                returned++;
            end
            if (credits < 0 || credits > fifoDepth) begin
                $display("credit counter left its range in test %s: %0d", testName, credits);
                errors++;
            end
            if (sendIdx < 2 * eventsPerPass && credits > 0
                    && !(stallOn && randBelow(4) != 0)) begin
                tdcIn <= '{valid: 1'b1, stamp: stamps[sendIdx]};
                credits--;
                sent++;
                sendIdx++;
            end else begin
                tdcIn <= '0;
            end
        end
    end

    // compares each result as it comes out
    always @(posedge clk) begin
        if (res && resValid) begin
            checkResult(testName, expected, result);
            checkCredits(testName, sent, returned, credits);
            doneCnt++;
        end
    end

    task automatic finishRun();
        $display("tests passed %0d, failed %0d, check errors %0d", passTests, failTests, errors);
        if (failTests == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic launchRun();
        @(posedge clk);
        tdcArm <= 1'b1;
        @(posedge clk);
        tdcArm <= 1'b0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic runTest(input string name);
        int errBefore;
        int seen;
        int waited;
        if (hung) begin
            return;
        end
        errBefore = errors;
        expected = peakRef(stamps);
        testName = name;
        seen = doneCnt;
        launchRun();
        waited = 0;
        while (doneCnt == seen && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (doneCnt == seen) begin
            $display("test %s timed out, no result after %0d cycles", name, maxWait);
            failTests++;
            hung = 1'b1;
        end else begin
            if (errors == errBefore) begin
                passTests++;
            end else begin
                failTests++;
            end
            $display("test %-10s %s", name, (errors == errBefore) ? "ok" : "wrong");
        end
    endtask

    task automatic resetMidRun(input string name);
        int errBefore;
        if (hung) begin
            return;
        end
        errBefore = errors;
        testName = name;
        fillRandom();
        launchRun();
        repeat (150) @(posedge clk);    // well inside build1
        res <= 1'b0;
        @(negedge clk);
        if (resValid !== 1'b0 || creditReturn !== 1'b0) begin
            $display("resValid or creditReturn not low during reset in test %s", name);
            errors++;
        end
        repeat (2) @(posedge clk);
        res <= 1'b1;
        if (errors == errBefore) begin
            passTests++;
        end else begin
            failTests++;
        end
        $display("test %-10s %s", name, (errors == errBefore) ? "ok" : "wrong");
    endtask

    initial begin
        int center;
        repeat (2) @(posedge clk);
        res <= 1'b1;

        fillRandom();
        center = 40 + randBelow(900);
        plantCluster(0, 40, center, 8);
        plantCluster(eventsPerPass, 40, center, 8);
        runTest("cluster");

        buildTies();
        runTest("ties");

        stamps = '{default: 10'd500};   // every event back to back into one bin
        runTest("saturation");

        fillRandom();
        plantCluster(0, 40, 0, 4);
        plantCluster(eventsPerPass, 40, 0, 6);
        runTest("clampLow");

        fillRandom();
        plantCluster(0, 40, 1016, 8);
        plantCluster(eventsPerPass, 40, 1018, 6);
        runTest("clampHigh");

        buildBursts();
        stallOn <= 1'b1;
        runTest("burstStall");
        stallOn <= 1'b0;

        fillRandom();
        center = 40 + randBelow(900);
        plantCluster(0, 30, center, 16);
        plantCluster(eventsPerPass, 30, center, 16);
        runTest("rerun");

        resetMidRun("midReset");

        fillRandom();
        center = 40 + randBelow(900);
        plantCluster(0, 40, center, 8);
        plantCluster(eventsPerPass, 40, center, 8);
        runTest("afterReset");

        finishRun();
    end

endmodule
